// File: list.f
ecc_pkg.sv
ecc_write_port.sv
ecc_mem_array.sv
ecc_32_top.sv
ecc_read_port.sv
ecc_err_log.sv
ecc_mem_top.sv
ecc_mem_properties.sv
tb_ecc_mem.sv

// File: tb_ecc_mem.sv
`timescale 1ns/10ps

module tb_ecc_mem;

    localparam int clean_ops  = 64 + 40;
    localparam int single_ops = 39 * 2;
    localparam int double_ops = 20 * 2;
    localparam int bypass_ops = 2 + 16;
    localparam int rmw_ops    = 8 * 3;
    localparam int sat_reads  = 65540;
    localparam int sat_ops    = 2 + sat_reads;
    localparam int total_ops  = clean_ops + single_ops + double_ops + bypass_ops
                              + rmw_ops + sat_ops;

    logic                           clk;
    logic                           rst_n;
    logic                           wr_en;
    logic [ecc_pkg::addr_width-1:0] wr_addr;
    logic [ecc_pkg::data_width-1:0] wr_data;
    logic [ecc_pkg::code_width-1:0] inj_mask;
    logic                           rd_en;
    logic [ecc_pkg::addr_width-1:0] rd_addr;
    logic                           bypass;
    logic [ecc_pkg::data_width-1:0] rd_data;
    logic                           rd_valid;
    logic                           sbit_err;
    logic                           dbit_err;
    logic [ecc_pkg::cnt_width-1:0]  sbit_count;
    logic [ecc_pkg::cnt_width-1:0]  dbit_count;
    logic [ecc_pkg::addr_width-1:0] last_err_addr;

    // The model keeps the written data and the flips applied at each address.
    logic [ecc_pkg::data_width-1:0] model_data [64];
    logic [ecc_pkg::code_width-1:0] model_mask [64];

    // Each entry is {addr, dbit, sbit, data}.
    logic [39:0]                    exp_q [$];
    logic [ecc_pkg::cnt_width-1:0]  exp_sbit_cnt;
    logic [ecc_pkg::cnt_width-1:0]  exp_dbit_cnt;
    logic [ecc_pkg::addr_width-1:0] exp_last_addr;
    logic [31:0]                    rng;
    int                             error_count;
    int                             reads_checked;

    ecc_mem_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .inj_mask     (inj_mask),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .bypass       (bypass),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err),
        .sbit_count   (sbit_count),
        .dbit_count   (dbit_count),
        .last_err_addr(last_err_addr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Result is {dbit, sbit, data}. Every code column has odd weight, so any
    // two distinct flips are detected and left uncorrected.
    function automatic logic [33:0] expected_read(
        input logic [31:0] data,
        input logic [38:0] mask,
        input logic        byp
    );
        logic [31:0] raw;
        int          flips;
        raw   = data ^ mask[31:0];
        flips = $countones(mask);
        if (byp) begin
            return {2'b00, raw};
        end
        if (flips == 0) begin
            return {2'b00, data};
        end
        if (flips == 1) begin
            return {2'b01, data};
        end
        return {2'b10, raw};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expv,
                                   input logic [63:0] actv);
        $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expv, actv);
        error_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        error_count++;
    endtask

    // One clock of stimulus. A read sees the model before this cycle's write.
    task automatic drive_cycle(
        input logic        do_wr,
        input logic [5:0]  waddr,
        input logic [31:0] wdata,
        input logic [38:0] mask,
        input logic        do_rd,
        input logic [5:0]  raddr,
        input logic        byp
    );
        logic [33:0] res;
        @(negedge clk);
        wr_en    = do_wr;
        wr_addr  = waddr;
        wr_data  = wdata;
        inj_mask = mask;
        rd_en    = do_rd;
        rd_addr  = raddr;
        bypass   = byp;
        if (do_rd) begin
            res = expected_read(model_data[raddr], model_mask[raddr], byp);
            exp_q.push_back({raddr, res});
        end
        if (do_wr) begin
            model_data[waddr] = wdata;
            model_mask[waddr] = mask;
        end
    endtask

    task automatic write_word(input logic [5:0] addr, input logic [31:0] data,
                              input logic [38:0] mask);
        drive_cycle(1'b1, addr, data, mask, 1'b0, 6'd0, 1'b0);
    endtask

    task automatic read_word(input logic [5:0] addr, input logic byp);
        drive_cycle(1'b0, 6'd0, 32'd0, 39'd0, 1'b1, addr, byp);
    endtask

    task automatic idle_cycle;
        drive_cycle(1'b0, 6'd0, 32'd0, 39'd0, 1'b0, 6'd0, 1'b0);
    endtask

    task automatic drain;
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
        idle_cycle();
        idle_cycle();
    endtask

    task automatic apply_reset;
        @(negedge clk);
        rst_n = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(total_ops * 10 * 10 + 1000);
        $display("ERROR: watchdog expired with %0d errors and %0d reads checked",
                 error_count, reads_checked);
        $display("TEST FAILED");
        $finish;
    end

    // Results come back two cycles after rd_en and are checked where they are stable.
    initial begin : compare_proc
        logic        due;
        logic        pipe1;
        logic [39:0] entry;
        due   = 1'b0;
        pipe1 = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                due           = 1'b0;
                pipe1         = 1'b0;
                exp_sbit_cnt  = '0;
                exp_dbit_cnt  = '0;
                exp_last_addr = '0;
            end else begin
                due   = pipe1;
                pipe1 = rd_en;
            end
            @(negedge clk);
            if (sbit_count !== exp_sbit_cnt) begin
                report_mismatch("sbit_count", exp_sbit_cnt, sbit_count);
            end
            if (dbit_count !== exp_dbit_cnt) begin
                report_mismatch("dbit_count", exp_dbit_cnt, dbit_count);
            end
            if (last_err_addr !== exp_last_addr) begin
                report_mismatch("last_err_addr", exp_last_addr, last_err_addr);
            end
            if (rd_valid !== due) begin
                report_mismatch("rd_valid", due, rd_valid);
            end
            if (due && exp_q.size() == 0) begin
                report_problem("a read result arrived with no expected value queued");
            end else if (due) begin
                entry = exp_q.pop_front();
                if (rd_data !== entry[31:0]) begin
                    report_mismatch("rd_data", entry[31:0], rd_data);
                end
                if (sbit_err !== entry[32]) begin
                    report_mismatch("sbit_err", entry[32], sbit_err);
                end
                if (dbit_err !== entry[33]) begin
                    report_mismatch("dbit_err", entry[33], dbit_err);
                end
                if (entry[32] && exp_sbit_cnt != '1) begin
                    exp_sbit_cnt = exp_sbit_cnt + 1'b1;
                end
                if (entry[33] && exp_dbit_cnt != '1) begin
                    exp_dbit_cnt = exp_dbit_cnt + 1'b1;
                end
                if (entry[32] || entry[33]) begin
                    exp_last_addr = entry[39:34];
                end
                reads_checked++;
            end else begin
                if (sbit_err !== 1'b0) begin
                    report_mismatch("sbit_err", 1'b0, sbit_err);
                end
                if (dbit_err !== 1'b0) begin
                    report_mismatch("dbit_err", 1'b0, dbit_err);
                end
            end
        end
    end

    initial begin : stimulus
        logic [5:0]  addr;
        logic [38:0] mask;
        int          p_a;
        int          p_b;
        rst_n         = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        inj_mask      = '0;
        rd_en         = 1'b0;
        rd_addr       = '0;
        bypass        = 1'b0;
        rng           = 32'h51ee;
        error_count   = 0;
        reads_checked = 0;
        exp_sbit_cnt  = '0;
        exp_dbit_cnt  = '0;
        exp_last_addr = '0;
        apply_reset();

        // Clean contents everywhere, then back-to-back reads.
        for (int i = 0; i < 64; i++) begin
            rng = xorshift32(rng);
            write_word(i[5:0], rng, 39'd0);
        end
        idle_cycle();
        for (int i = 0; i < 40; i++) begin
            rng = xorshift32(rng);
            read_word(rng[5:0], 1'b0);
        end
        drain();

        for (int pos = 0; pos < 39; pos++) begin
            rng = xorshift32(rng);
            addr = rng[5:0];
            rng = xorshift32(rng);
            write_word(addr, rng, 39'd1 << pos);
            idle_cycle();
            read_word(addr, 1'b0);
        end
        drain();

        for (int i = 0; i < 20; i++) begin
            rng = xorshift32(rng);
            p_a = rng % 39;
            rng = xorshift32(rng);
            p_b = (p_a + 1 + (rng % 38)) % 39;
            mask = (39'd1 << p_a) | (39'd1 << p_b);
            rng = xorshift32(rng);
            addr = rng[5:0];
            rng = xorshift32(rng);
            write_word(addr, rng, mask);
            idle_cycle();
            read_word(addr, 1'b0);
        end
        drain();

        // Raw reads of words holding zero, one and two flips.
        rng = xorshift32(rng);
        write_word(6'd7, rng, (39'd1 << 3) | (39'd1 << 35));
        rng = xorshift32(rng);
        write_word(6'd9, rng, 39'd1 << 20);
        idle_cycle();
        read_word(6'd7, 1'b1);
        read_word(6'd9, 1'b1);
        for (int i = 0; i < 14; i++) begin
            rng = xorshift32(rng);
            read_word(rng[5:0], 1'b1);
        end
        drain();

        // Read and write to one address in one cycle, then read it again.
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            addr = rng[5:0];
            rng = xorshift32(rng);
            drive_cycle(1'b1, addr, rng, 39'd0, 1'b1, addr, 1'b0);
            idle_cycle();
            read_word(addr, 1'b0);
        end
        drain();

        // Fresh reset, then enough single errors to saturate sbit_count.
        apply_reset();
        rng = xorshift32(rng);
        p_a = rng % 39;
        rng = xorshift32(rng);
        write_word(6'd3, rng, 39'd1 << p_a);
        idle_cycle();
        for (int i = 0; i < sat_reads; i++) begin
            read_word(6'd3, 1'b0);
        end
        drain();
        if (sbit_count !== 16'hffff) begin
            report_mismatch("sbit_count", 16'hffff, sbit_count);
        end

        error_count = error_count + dut0.u_props.fail_count;
        $display("%0d errors, %0d reads checked", error_count, reads_checked);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: ecc_mem_properties.sv
`timescale 1ns/10ps

module ecc_mem_properties (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          rd_en,
    input logic                          rd_valid,
    input logic                          sbit_err,
    input logic                          dbit_err,
    input logic [ecc_pkg::cnt_width-1:0] sbit_count,
    input logic [ecc_pkg::cnt_width-1:0] dbit_count
);

    int fail_count = 0;

    // A read is either correctable or uncorrectable, never both.
    flags_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(sbit_err && dbit_err)
    ) else begin
        $error("sbit_err and dbit_err are high in the same cycle");
        fail_count++;
    end

    flags_need_valid: assert property (
        @(posedge clk) disable iff (!rst_n) (sbit_err || dbit_err) |-> rd_valid
    ) else begin
        $error("an error flag is high while rd_valid is low");
        fail_count++;
    end

    // Read latency is fixed at two cycles.
    valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n) rd_valid == $past(rd_en, 2)
    ) else begin
        $error("rd_valid does not follow rd_en by two cycles");
        fail_count++;
    end

    sbit_count_monotonic: assert property (
        @(posedge clk) disable iff (!rst_n) $past(rst_n) |-> sbit_count >= $past(sbit_count)
    ) else begin
        $error("sbit_count decreased outside reset");
        fail_count++;
    end

    dbit_count_monotonic: assert property (
        @(posedge clk) disable iff (!rst_n) $past(rst_n) |-> dbit_count >= $past(dbit_count)
    ) else begin
        $error("dbit_count decreased outside reset");
        fail_count++;
    end

endmodule

bind ecc_mem_top ecc_mem_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .rd_valid  (rd_valid),
    .sbit_err  (sbit_err),
    .dbit_err  (dbit_err),
    .sbit_count(sbit_count),
    .dbit_count(dbit_count)
);

// File: ecc_mem_top.sv
`timescale 1ns/10ps

module ecc_mem_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  logic [ecc_pkg::addr_width-1:0] wr_addr,
    input  logic [ecc_pkg::data_width-1:0] wr_data,
    input  logic [ecc_pkg::code_width-1:0] inj_mask,
    input  logic                           rd_en,
    input  logic [ecc_pkg::addr_width-1:0] rd_addr,
    input  logic                           bypass,
    output logic [ecc_pkg::data_width-1:0] rd_data,
    output logic                           rd_valid,
    output logic                           sbit_err,
    output logic                           dbit_err,
    output logic [ecc_pkg::cnt_width-1:0]  sbit_count,
    output logic [ecc_pkg::cnt_width-1:0]  dbit_count,
    output logic [ecc_pkg::addr_width-1:0] last_err_addr
);

    logic                           mem_we;
    logic [ecc_pkg::addr_width-1:0] mem_waddr;
    logic [ecc_pkg::code_width-1:0] mem_wcode;
    logic [ecc_pkg::code_width-1:0] mem_rcode;
    logic [ecc_pkg::addr_width-1:0] err_addr;

    ecc_write_port u_wr (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .inj_mask (inj_mask),
        .mem_we   (mem_we),
        .mem_waddr(mem_waddr),
        .mem_wcode(mem_wcode)
    );

    ecc_mem_array u_mem (
        .clk      (clk),
        .mem_we   (mem_we),
        .mem_waddr(mem_waddr),
        .mem_wcode(mem_wcode),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .mem_rcode(mem_rcode)
    );

    ecc_read_port u_rd (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .bypass   (bypass),
        .mem_rcode(mem_rcode),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err),
        .err_addr (err_addr)
    );

    ecc_err_log u_log (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_valid     (rd_valid),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err),
        .err_addr     (err_addr),
        .sbit_count   (sbit_count),
        .dbit_count   (dbit_count),
        .last_err_addr(last_err_addr)
    );

endmodule

// File: ecc_err_log.sv
`timescale 1ns/10ps

module ecc_err_log (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rd_valid,
    input  logic                           sbit_err,
    input  logic                           dbit_err,
    input  logic [ecc_pkg::addr_width-1:0] err_addr,
    output logic [ecc_pkg::cnt_width-1:0]  sbit_count,
    output logic [ecc_pkg::cnt_width-1:0]  dbit_count,
    output logic [ecc_pkg::addr_width-1:0] last_err_addr
);

    logic sbit_event;
    logic dbit_event;
    logic sbit_full;
    logic dbit_full;

    assign sbit_event = rd_valid && sbit_err;
    assign dbit_event = rd_valid && dbit_err;
    assign sbit_full  = &sbit_count;
    assign dbit_full  = &dbit_count;

    // Counters stick at all ones.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sbit_count <= '0;
            dbit_count <= '0;
        end else begin
            if (sbit_event && !sbit_full) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dbit_event && !dbit_full) begin
                dbit_count <= dbit_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_err_addr <= '0;
        end else if (sbit_event || dbit_event) begin
            last_err_addr <= err_addr;
        end
    end

endmodule

// File: ecc_read_port.sv
`timescale 1ns/10ps

module ecc_read_port (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rd_en,
    input  logic [ecc_pkg::addr_width-1:0] rd_addr,
    input  logic                           bypass,
    input  logic [ecc_pkg::code_width-1:0] mem_rcode,
    output logic [ecc_pkg::data_width-1:0] rd_data,
    output logic                           rd_valid,
    output logic                           sbit_err,
    output logic                           dbit_err,
    output logic [ecc_pkg::addr_width-1:0] err_addr
);

    logic                           valid_d1;
    logic [ecc_pkg::addr_width-1:0] addr_d1;
    logic                           bypass_d1;
    ecc_pkg::ecc_codeword_u         rcode;
    logic [ecc_pkg::data_width-1:0] dec_data;
    logic                           dec_sbit;
    logic                           dec_dbit;

    assign rcode.flat = mem_rcode;

    ecc_32_top u_dec (
        .data_in   (rcode.fields.data),
        .data_out  (dec_data),
        .parity_in (rcode.fields.parity),
        .parity_out(),
        .bypass    (bypass_d1),
        .sbit_err  (dec_sbit),
        .dbit_err  (dec_dbit)
    );

    // First stage runs alongside the array read.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d1 <= 1'b0;
        end else begin
            valid_d1 <= rd_en;
        end
        addr_d1   <= rd_addr;
        bypass_d1 <= bypass;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
        end else begin
            rd_valid <= valid_d1;
            sbit_err <= valid_d1 && dec_sbit;
            dbit_err <= valid_d1 && dec_dbit;
        end
        rd_data  <= dec_data;
        err_addr <= addr_d1;
    end

endmodule

// File: ecc_32_top.sv
`timescale 1ns/10ps

module ecc_32_top (
    input  logic [32-1:0] data_in,
    output logic [32-1:0] data_out,
    input  logic [ 7-1:0] parity_in,
    output logic [ 7-1:0] parity_out,
    input  logic          bypass,
    output logic          sbit_err,
    output logic          dbit_err
);

    logic [6:0]  syndrome;
    logic [5:0]  flip;
    logic [31:0] mask;
    logic        check_hit;
    logic        single;

    assign parity_out = ecc_pkg::ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // Map a data-bit syndrome to {hit, bit index}.
    always_comb begin
        flip = '0;
        case (syndrome)
            7'h43: flip = {1'b1, 5'd0};
            7'h45: flip = {1'b1, 5'd1};
            7'h46: flip = {1'b1, 5'd2};
            7'h07: flip = {1'b1, 5'd3};
            7'h49: flip = {1'b1, 5'd4};
            7'h4a: flip = {1'b1, 5'd5};
            7'h0b: flip = {1'b1, 5'd6};
            7'h4c: flip = {1'b1, 5'd7};
            7'h0d: flip = {1'b1, 5'd8};
            7'h0e: flip = {1'b1, 5'd9};
            7'h4f: flip = {1'b1, 5'd10};
            7'h51: flip = {1'b1, 5'd11};
            7'h52: flip = {1'b1, 5'd12};
            7'h13: flip = {1'b1, 5'd13};
            7'h54: flip = {1'b1, 5'd14};
            7'h15: flip = {1'b1, 5'd15};
            7'h16: flip = {1'b1, 5'd16};
            7'h57: flip = {1'b1, 5'd17};
            7'h58: flip = {1'b1, 5'd18};
            7'h19: flip = {1'b1, 5'd19};
            7'h1a: flip = {1'b1, 5'd20};
            7'h5b: flip = {1'b1, 5'd21};
            7'h1c: flip = {1'b1, 5'd22};
            7'h5d: flip = {1'b1, 5'd23};
            7'h5e: flip = {1'b1, 5'd24};
            7'h1f: flip = {1'b1, 5'd25};
            7'h61: flip = {1'b1, 5'd26};
            7'h62: flip = {1'b1, 5'd27};
            7'h23: flip = {1'b1, 5'd28};
            7'h64: flip = {1'b1, 5'd29};
            7'h25: flip = {1'b1, 5'd30};
            7'h26: flip = {1'b1, 5'd31};
            default: flip = '0;
        endcase
    end

    // A one-hot syndrome means a check bit flipped and the data is intact.
    assign check_hit = (syndrome != 7'd0) && ((syndrome & (syndrome - 7'd1)) == 7'd0);
    assign single    = flip[5] | check_hit;
    assign mask      = flip[5] ? (32'd1 << flip[4:0]) : 32'd0;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = !bypass && single;
    // Anything nonzero that is not a known single error is uncorrectable.
    assign dbit_err = !bypass && (syndrome != 7'd0) && !single;

endmodule

// File: ecc_mem_array.sv
`timescale 1ns/10ps

module ecc_mem_array (
    input  logic                           clk,
    input  logic                           mem_we,
    input  logic [ecc_pkg::addr_width-1:0] mem_waddr,
    input  logic [ecc_pkg::code_width-1:0] mem_wcode,
    input  logic                           rd_en,
    input  logic [ecc_pkg::addr_width-1:0] rd_addr,
    output logic [ecc_pkg::code_width-1:0] mem_rcode
);

    localparam int depth = 1 << ecc_pkg::addr_width;

    logic [ecc_pkg::code_width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wcode;
        end
    end

    // Nonblocking read of the old entry gives read-first behaviour when a
    // read and a write hit the same address on the same edge.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            mem_rcode <= mem[rd_addr];
        end
    end

endmodule

// File: ecc_write_port.sv
`timescale 1ns/10ps

module ecc_write_port (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  logic [ecc_pkg::addr_width-1:0] wr_addr,
    input  logic [ecc_pkg::data_width-1:0] wr_data,
    input  logic [ecc_pkg::code_width-1:0] inj_mask,
    output logic                           mem_we,
    output logic [ecc_pkg::addr_width-1:0] mem_waddr,
    output logic [ecc_pkg::code_width-1:0] mem_wcode
);

    ecc_pkg::ecc_codeword_u clean_code;
    ecc_pkg::ecc_codeword_u faulty_code;

    always_comb begin
        clean_code.fields.data   = wr_data;
        clean_code.fields.parity = ecc_pkg::ecc_encode(wr_data);
    end

    // Fault injection works on raw bit positions, so it uses the flat view.
    always_comb begin
        faulty_code.flat = clean_code.flat ^ inj_mask;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_we <= 1'b0;
        end else begin
            mem_we <= wr_en;
        end
    end

    // Address and codeword only matter while mem_we is high.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_waddr <= wr_addr;
            mem_wcode <= faulty_code.flat;
        end
    end

endmodule

// File: ecc_pkg.sv
package ecc_pkg;

    localparam int data_width   = 32;
    localparam int parity_width = 7;
    localparam int code_width   = 39;
    localparam int addr_width   = 6;
    localparam int cnt_width    = 16;

    // One stored codeword. The field view feeds storage and decode, and the
    // flat view lets a fault mask flip any bit by its position.
    typedef union packed {
        struct packed {
            logic [parity_width-1:0] parity;
            logic [data_width-1:0]   data;
        } fields;
        logic [code_width-1:0] flat;
    } ecc_codeword_u;

    // Hsiao check bits. Every data column has odd weight.
    function automatic logic [parity_width-1:0] ecc_encode(
        input logic [data_width-1:0] d
    );
        logic [parity_width-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13]
             ^ d[15] ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28]
             ^ d[30];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13]
             ^ d[16] ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28]
             ^ d[31];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15]
             ^ d[16] ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30]
             ^ d[31];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[18] ^ d[19]
             ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24] ^ d[25];
        p[4] = d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24] ^ d[25];
        p[5] = d[26] ^ d[27] ^ d[28] ^ d[29] ^ d[30] ^ d[31];
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12]
             ^ d[14] ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27]
             ^ d[29];
        return p;
    endfunction

endpackage
